/* verilog/icache_defines.svh */
// Instruction cache sizes
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address and its fields.
`define ICACHE_ADDR_W   64
`define ICACHE_TAG_W    22
`define ICACHE_TAG_LSB  10
`define ICACHE_INDEX_W  6

// array geometry.
`define ICACHE_SETS     64
`define ICACHE_LINE_W   128

// refill beat from memory.
`define ICACHE_BEAT_W   64

// replacement age counters, saturating.
`define ICACHE_AGE_W    3
`define ICACHE_AGE_MAX  7

`endif

/* verilog/icache_pkg.sv */
// Instruction cache types
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [`ICACHE_BEAT_W-1:0] beat_t;

    // number of 32-bit words wanted, 1 to 4.
    typedef logic [2:0] count_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [`ICACHE_AGE_W-1:0] age_t;

endpackage

`default_nettype wire

/* verilog/icache_way_if.sv */
// Cache way storage interface
`default_nettype none

interface icache_way_if;

    icache_pkg::index_t     index;
    logic                   tag_we;
    icache_pkg::tag_entry_t tag_wdata;
    logic                   line_we;
    icache_pkg::line_t      line_wdata;

    // registered read, one cycle after index.
    icache_pkg::tag_entry_t tag_rdata;
    icache_pkg::line_t      line_rdata;

    modport ctrl (
        output index, tag_we, tag_wdata, line_we, line_wdata,
        input  tag_rdata, line_rdata
    );

    modport store (
        input  index, tag_we, tag_wdata, line_we, line_wdata,
        output tag_rdata, line_rdata
    );

endinterface

`default_nettype wire

/* verilog/icache_sram.sv */
// Single-port cache storage array
`default_nettype none

`include "icache_defines.svh"

module icache_sram #(
    parameter type entry_t = icache_pkg::line_t,
    parameter int  depth   = `ICACHE_SETS
) (
    input  wire                     clk,
    input  wire icache_pkg::index_t index_i,
    input  wire                     we_i,
    input  wire entry_t             wdata_i,
    output entry_t                  rdata_o
);

    entry_t mem [depth];

    // read-before-write on the same set.
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[index_i] <= wdata_i;
        end
        rdata_o <= mem[index_i];
    end

endmodule

`default_nettype wire

/* verilog/icache_age.sv */
// Way age counters and victim select
`default_nettype none

`include "icache_defines.svh"

module icache_age (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire icache_pkg::index_t index_i,
    input  wire                     tick_i,
    input  wire                     hit0_i,
    input  wire                     hit1_i,
    input  wire                     fill0_i,
    input  wire                     fill1_i,
    output logic                    victim_o
);

    icache_pkg::age_t age0 [`ICACHE_SETS];
    icache_pkg::age_t age1 [`ICACHE_SETS];

    // clear wins over the tick.
    function automatic icache_pkg::age_t next_age(input icache_pkg::age_t cur,
                                                  input logic clr,
                                                  input logic tick);
        if (clr) begin
            return '0;
        end
        if (tick && cur != icache_pkg::age_t'(`ICACHE_AGE_MAX)) begin
            return cur + 1'b1;
        end
        return cur;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                age0[s] <= next_age(age0[s],
                                    (hit0_i || fill0_i) && index_i == icache_pkg::index_t'(s),
                                    tick_i);
                age1[s] <= next_age(age1[s],
                                    (hit1_i || fill1_i) && index_i == icache_pkg::index_t'(s),
                                    tick_i);
            end
        end
    end

    // older way goes, way 0 on a tie.
    assign victim_o = (age0[index_i] >= age1[index_i]) ? 1'b0 : 1'b1;

endmodule

`default_nettype wire

/* verilog/icache_refill.sv */
// Two-beat line refill
`default_nettype none

`include "icache_defines.svh"

module icache_refill (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     start_i,
    input  wire icache_pkg::addr_t  line_addr_i,
    output logic                    mem_req_o,
    output icache_pkg::addr_t       mem_addr_o,
    input  wire icache_pkg::beat_t  mem_data_i,
    input  wire                     mem_valid_i,
    output logic                    done_o,
    output icache_pkg::line_t       line_o
);

    logic              busy_q;
    logic              upper_q;
    logic              done_q;
    icache_pkg::addr_t addr_q;
    icache_pkg::line_t line_q;

    logic beat_ok;
    assign beat_ok = busy_q && mem_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            upper_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q  <= 1'b1;
                upper_q <= 1'b0;
            end else if (beat_ok) begin
                if (upper_q) begin
                    busy_q  <= 1'b0;
                    upper_q <= 1'b0;
                    done_q  <= 1'b1;
                end else begin
                    upper_q <= 1'b1;
                end
            end
        end
    end

    // line base first, then base plus 8.
    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            addr_q <= {line_addr_i[`ICACHE_ADDR_W-1:4], 4'b0000};
        end else if (beat_ok && !upper_q) begin
            addr_q[3] <= 1'b1;
        end
        if (beat_ok) begin
            if (upper_q) begin
                line_q[`ICACHE_LINE_W-1 -: `ICACHE_BEAT_W] <= mem_data_i;
            end else begin
                line_q[`ICACHE_BEAT_W-1:0] <= mem_data_i;
            end
        end
    end

    assign mem_req_o  = busy_q;
    assign mem_addr_o = addr_q;
    assign done_o     = done_q;
    assign line_o     = line_q;

endmodule

`default_nettype wire

/* verilog/icache_ctrl.sv */
// Instruction cache controller
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     fetch_valid_i,
    input  wire icache_pkg::addr_t  fetch_addr_i,
    input  wire icache_pkg::count_t fetch_count_i,
    input  wire                     fence_i,
    output logic                    fetch_ready_o,
    output logic                    rsp_valid_o,
    output icache_pkg::line_t       rsp_data_o,
    icache_way_if.ctrl              way0,
    icache_way_if.ctrl              way1,
    output logic                    refill_start_o,
    output icache_pkg::addr_t       refill_addr_o,
    input  wire                     refill_done_i,
    input  wire icache_pkg::line_t  refill_line_i,
    output logic                    age_tick_o,
    output logic                    age_hit0_o,
    output logic                    age_hit1_o,
    output logic                    age_fill0_o,
    output logic                    age_fill1_o,
    input  wire                     age_victim_i
);

    typedef enum logic [2:0] {
        s_idle,
        s_read,
        s_lookup,
        s_refill,
        s_fence
    } state_t;

    state_t              state_q;
    icache_pkg::addr_t   addr_q;
    icache_pkg::count_t  count_q;
    icache_pkg::index_t  fence_idx_q;
    logic                fill_way_q;

    icache_pkg::tag_t       tag_q;
    icache_pkg::index_t     index_q;
    icache_pkg::tag_entry_t wr_entry;
    logic accept, in_lookup, hit0, hit1, hit, miss_way, fill_write, sweep;

    assign tag_q   = addr_q[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
    assign index_q = addr_q[`ICACHE_TAG_LSB - `ICACHE_INDEX_W +: `ICACHE_INDEX_W];

    // a fence in idle wins over a fetch.
    assign fetch_ready_o = (state_q == s_idle) && !fence_i;
    assign accept        = fetch_valid_i && fetch_ready_o;
    assign in_lookup     = (state_q == s_lookup);
    assign sweep         = (state_q == s_fence);
    assign fill_write    = (state_q == s_refill) && refill_done_i;

    assign hit0 = way0.tag_rdata.valid && way0.tag_rdata.tag == tag_q;
    assign hit1 = way1.tag_rdata.valid && way1.tag_rdata.tag == tag_q;
    assign hit  = hit0 || hit1;

    // an empty way before the age victim.
    assign miss_way = !way0.tag_rdata.valid ? 1'b0 :
                      !way1.tag_rdata.valid ? 1'b1 : age_victim_i;

    function automatic icache_pkg::line_t mask_line(input icache_pkg::line_t line,
                                                    input icache_pkg::count_t count);
        case (count)
            3'd1:    return {line[127:96], 96'b0};
            3'd2:    return {line[127:64], 64'b0};
            3'd3:    return {line[127:32], 32'b0};
            3'd4:    return line;
            default: return '0;
        endcase
    endfunction

    assign rsp_valid_o    = in_lookup && hit;
    assign rsp_data_o     = mask_line(hit0 ? way0.line_rdata : way1.line_rdata, count_q);
    assign refill_start_o = in_lookup && !hit;
    assign refill_addr_o  = addr_q;

    assign age_tick_o  = accept;
    assign age_hit0_o  = in_lookup && hit0;
    assign age_hit1_o  = in_lookup && hit1 && !hit0;
    assign age_fill0_o = fill_write && !fill_way_q;
    assign age_fill1_o = fill_write && fill_way_q;

    assign wr_entry = sweep ? icache_pkg::tag_entry_t'{valid: 1'b0, tag: '0} :
                              icache_pkg::tag_entry_t'{valid: 1'b1, tag: tag_q};

    assign way0.index      = sweep ? fence_idx_q : index_q;
    assign way0.tag_we     = sweep || age_fill0_o;
    assign way0.tag_wdata  = wr_entry;
    assign way0.line_we    = age_fill0_o;
    assign way0.line_wdata = refill_line_i;

    assign way1.index      = sweep ? fence_idx_q : index_q;
    assign way1.tag_we     = sweep || age_fill1_o;
    assign way1.tag_wdata  = wr_entry;
    assign way1.line_we    = age_fill1_o;
    assign way1.line_wdata = refill_line_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= s_idle;
            fence_idx_q <= '0;
            fill_way_q  <= 1'b0;
        end else begin
            case (state_q)
                s_idle: begin
                    if (fence_i) begin
                        state_q <= s_fence;
                    end else if (accept) begin
                        state_q <= s_read;
                    end
                end
                s_read: state_q <= s_lookup;
                s_lookup: begin
                    state_q    <= hit ? s_idle : s_refill;
                    fill_way_q <= miss_way;
                end
                s_refill: begin
                    if (refill_done_i) begin
                        state_q <= s_read;
                    end
                end
                s_fence: begin
                    // wraps back to zero after the last set.
                    fence_idx_q <= fence_idx_q + 1'b1;
                    if (&fence_idx_q) begin
                        state_q <= s_idle;
                    end
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= fetch_addr_i;
            count_q <= fetch_count_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/icache_top.sv */
// Two-way instruction cache
`default_nettype none

module icache_top (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     fetch_valid_i,
    input  wire icache_pkg::addr_t  fetch_addr_i,
    input  wire icache_pkg::count_t fetch_count_i,
    input  wire                     fence_i,
    output logic                    fetch_ready_o,
    output logic                    rsp_valid_o,
    output icache_pkg::line_t       rsp_data_o,
    output logic                    mem_req_o,
    output icache_pkg::addr_t       mem_addr_o,
    input  wire icache_pkg::beat_t  mem_data_i,
    input  wire                     mem_valid_i
);

    logic              refill_start;
    icache_pkg::addr_t refill_addr;
    logic              refill_done;
    icache_pkg::line_t refill_line;
    logic age_tick, age_hit0, age_hit1, age_fill0, age_fill1, age_victim;

    icache_way_if way0_if ();
    icache_way_if way1_if ();

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_count_i  (fetch_count_i),
        .fence_i        (fence_i),
        .fetch_ready_o  (fetch_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_data_o     (rsp_data_o),
        .way0           (way0_if.ctrl),
        .way1           (way1_if.ctrl),
        .refill_start_o (refill_start),
        .refill_addr_o  (refill_addr),
        .refill_done_i  (refill_done),
        .refill_line_i  (refill_line),
        .age_tick_o     (age_tick),
        .age_hit0_o     (age_hit0),
        .age_hit1_o     (age_hit1),
        .age_fill0_o    (age_fill0),
        .age_fill1_o    (age_fill1),
        .age_victim_i   (age_victim)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (refill_start),
        .line_addr_i (refill_addr),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_data_i  (mem_data_i),
        .mem_valid_i (mem_valid_i),
        .done_o      (refill_done),
        .line_o      (refill_line)
    );

    // both ways share the set index.
    icache_age u_age (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .index_i  (way0_if.index),
        .tick_i   (age_tick),
        .hit0_i   (age_hit0),
        .hit1_i   (age_hit1),
        .fill0_i  (age_fill0),
        .fill1_i  (age_fill1),
        .victim_o (age_victim)
    );

    icache_sram #(.entry_t(icache_pkg::tag_entry_t)) u_tag0 (
        .clk (clk), .index_i (way0_if.index), .we_i (way0_if.tag_we),
        .wdata_i (way0_if.tag_wdata), .rdata_o (way0_if.tag_rdata)
    );

    icache_sram #(.entry_t(icache_pkg::tag_entry_t)) u_tag1 (
        .clk (clk), .index_i (way1_if.index), .we_i (way1_if.tag_we),
        .wdata_i (way1_if.tag_wdata), .rdata_o (way1_if.tag_rdata)
    );

    icache_sram #(.entry_t(icache_pkg::line_t)) u_data0 (
        .clk (clk), .index_i (way0_if.index), .we_i (way0_if.line_we),
        .wdata_i (way0_if.line_wdata), .rdata_o (way0_if.line_rdata)
    );

    icache_sram #(.entry_t(icache_pkg::line_t)) u_data1 (
        .clk (clk), .index_i (way1_if.index), .we_i (way1_if.line_we),
        .wdata_i (way1_if.line_wdata), .rdata_o (way1_if.line_rdata)
    );

endmodule

`default_nettype wire

/* dv/icache_assertions.sv */
// Cache protocol assertions
`default_nettype none

module icache_assertions (
    input wire                    clk,
    input wire                    rst_n_i,
    input wire                    mem_req_o,
    input wire icache_pkg::addr_t mem_addr_o,
    input wire                    mem_valid_i,
    input wire                    rsp_valid_o,
    input wire                    fetch_ready_o
);

    int fail_count = 0;

    // a waiting request keeps its address.
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
        fail_count++;
        $error("memory request dropped or moved before its beat was taken");
    end

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o |=> !rsp_valid_o)
    else begin
        fail_count++;
        $error("response valid held for two cycles");
    end

    // no new fetch while a refill is out.
    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_o |-> !fetch_ready_o)
    else begin
        fail_count++;
        $error("fetch ready high during a memory request");
    end

endmodule

bind icache_top icache_assertions u_assertions (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_valid_i   (mem_valid_i),
    .rsp_valid_o   (rsp_valid_o),
    .fetch_ready_o (fetch_ready_o)
);

`default_nettype wire

/* dv/icache_tb.sv */
// Instruction cache testbench
`default_nettype none

`include "icache_defines.svh"

module icache_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_FETCH  = 400;

    logic               clk;
    logic               rst_n_i;
    logic               fetch_valid_i;
    icache_pkg::addr_t  fetch_addr_i;
    icache_pkg::count_t fetch_count_i;
    logic               fence_i;
    logic               fetch_ready_o;
    logic               rsp_valid_o;
    icache_pkg::line_t  rsp_data_o;
    logic               mem_req_o;
    icache_pkg::addr_t  mem_addr_o;
    icache_pkg::beat_t  mem_data_i;
    logic               mem_valid_i;

    integer            seed = 89;
    int                errors = 0;
    int                hits = 0;
    int                misses = 0;
    int                rsp_seen = 0;
    int                beats_total = 0;
    int                mem_delay = 0;
    logic              mem_pending = 1'b0;
    longint            cycle = 0;
    icache_pkg::addr_t beat_q [$];

    // reference model, per way and set.
    logic             m_valid [2][`ICACHE_SETS];
    icache_pkg::tag_t m_tag   [2][`ICACHE_SETS];
    int               m_age   [2][`ICACHE_SETS];

    icache_top u_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_count_i (fetch_count_i),
        .fence_i       (fence_i),
        .fetch_ready_o (fetch_ready_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_data_o    (rsp_data_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_i    (mem_data_i),
        .mem_valid_i   (mem_valid_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // memory contents, a fixed function of the beat address.
    function automatic icache_pkg::beat_t mem_word(input icache_pkg::addr_t addr);
        return {addr[31:0] ^ 32'hc3a5_96f0, addr[63:32] ^ (addr[31:0] * 32'h9e37_79b9)};
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // keeps the upper count words of a line.
    function automatic icache_pkg::line_t keep_upper(input icache_pkg::line_t line,
                                                     input int count);
        icache_pkg::line_t res;
        res = '0;
        for (int w = 4 - count; w < 4; w++) begin
            res[w*32 +: 32] = line[w*32 +: 32];
        end
        return res;
    endfunction

    // three tags over four sets, so ways conflict.
    function automatic icache_pkg::addr_t pick_addr();
        icache_pkg::tag_t   tag;
        icache_pkg::index_t set;
        tag = 22'h0002a5 + 22'(rand_below(3)) * 22'h011111;
        set = 6'(rand_below(4) * 21);
        return {32'h0, tag, set, 4'(rand_below(16))};
    endfunction

    // answers each beat after 0 to 5 cycles.
    always @(posedge clk) begin
        if (!rst_n_i) begin
            mem_valid_i <= 1'b0;
            mem_pending = 1'b0;
        end else if (mem_valid_i) begin
            mem_valid_i <= 1'b0;
        end else if (mem_req_o) begin
            if (!mem_pending) begin
                mem_pending = 1'b1;
                mem_delay   = rand_below(6);
                beat_q.push_back(mem_addr_o);
                beats_total++;
            end
            if (mem_delay == 0) begin
                mem_valid_i <= 1'b1;
                mem_data_i  <= mem_word(mem_addr_o);
                mem_pending = 1'b0;
            end else begin
                mem_delay--;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n_i && rsp_valid_o === 1'b1) begin
            rsp_seen++;
        end
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("mismatch %s: expected %h actual %h", name, exp, act);
    endtask

    // age tick, hit compare and fill, one fetch at a time.
    task automatic model_fetch(input icache_pkg::addr_t addr, output logic hit);
        icache_pkg::index_t set;
        icache_pkg::tag_t   tag;
        int                 way;
        set = addr[`ICACHE_TAG_LSB-1 -: `ICACHE_INDEX_W];
        tag = addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_age[w][s] < `ICACHE_AGE_MAX) begin
                    m_age[w][s]++;
                end
            end
        end
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == tag) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            if (!m_valid[0][set]) begin
                way = 0;
            end else if (!m_valid[1][set]) begin
                way = 1;
            end else begin
                way = (m_age[0][set] >= m_age[1][set]) ? 0 : 1;
            end
            m_valid[way][set] = 1'b1;
            m_tag[way][set]   = tag;
        end
        m_age[way][set] = 0;
    endtask

    task automatic run_fetch(input icache_pkg::addr_t addr, input int count);
        logic              hit;
        longint            t_acc;
        icache_pkg::addr_t base;
        icache_pkg::line_t exp_line;
        base     = {addr[63:4], 4'b0000};
        exp_line = keep_upper({mem_word(base + 8), mem_word(base)}, count);
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= addr;
        fetch_count_i <= icache_pkg::count_t'(count);
        @(posedge clk);
        while (fetch_ready_o !== 1'b1) begin
            @(posedge clk);
        end
        t_acc = cycle;
        fetch_valid_i <= 1'b0;
        model_fetch(addr, hit);
        @(posedge clk);
        while (rsp_valid_o !== 1'b1) begin
            @(posedge clk);
        end
        if (hit) begin
            hits++;
        end else begin
            misses++;
        end
        if (rsp_data_o !== exp_line) begin
            report_mismatch("line data", exp_line, rsp_data_o);
        end
        if (hit && cycle - t_acc != 2) begin
            report_mismatch("hit latency", 2, cycle - t_acc);
        end
        if (beat_q.size() != (hit ? 0 : 2)) begin
            report_mismatch("memory beat count", hit ? 0 : 2, beat_q.size());
        end else if (!hit && (beat_q[0] !== base || beat_q[1] !== base + 8)) begin
            report_mismatch("beat addresses", {base, base + 64'd8}, {beat_q[0], beat_q[1]});
        end
        beat_q.delete();
    endtask

    // sweep done once ready is back.
    task automatic run_fence();
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        @(posedge clk);
        while (fetch_ready_o !== 1'b1) begin
            @(posedge clk);
        end
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        fetch_count_i = 3'd1;
        fence_i       = 1'b0;
        mem_valid_i   = 1'b0;
        mem_data_i    = '0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s]   = '0;
                m_age[w][s]   = 0;
            end
        end
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        run_fence();
        for (int i = 0; i < NUM_FETCH; i++) begin
            if (i % 100 == 99) begin
                run_fence();
            end
            run_fetch(pick_addr(), 1 + rand_below(4));
        end
        repeat (4) @(posedge clk);
        if (rsp_seen != NUM_FETCH) begin
            errors++;
            $display("saw %0d responses for %0d accepted fetches", rsp_seen, NUM_FETCH);
        end
        if (beats_total != 2 * misses) begin
            errors++;
            $display("saw %0d memory beats for %0d misses", beats_total, misses);
        end
        errors += u_dut.u_assertions.fail_count;
        $display("fetches %0d hits %0d misses %0d errors %0d (assertion failures %0d)",
                 NUM_FETCH, hits, misses, errors, u_dut.u_assertions.fail_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // allows 60 cycles per fetch.
    initial begin
        #(NUM_FETCH * 60 * CLK_PERIOD);
        $display("watchdog timeout, the run did not finish within %0d fetch slots", NUM_FETCH);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_way_if.sv
verilog/icache_sram.sv
verilog/icache_age.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv
